/* common/matmul_defs.svh */
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// Width of one matrix element
`define MM_DWIDTH 8

// PEs per row and per column of the tile
`define MM_TILE 4

// Operand words per matrix, one word per k
`define MM_DEPTH 4
`define MM_AWIDTH 2

// Start to done latency
// Clear and first read, read latency, the remaining k words,
// skew plus travel to the far corner PE, and the MAC register
`define MM_COMPUTE_CYCLES (2 + (`MM_DEPTH - 1) + 2 * (`MM_TILE - 1) + 1)

// Result beats the host can take after reset
`define MM_CREDITS 2

`endif

/* common/matmul_data_pkg.sv */
`default_nettype none

`include "matmul_defs.svh"

package matmul_data_pkg;

  //////////////////////////////////////////////////
  // Matrix element and operand word
  //////////////////////////////////////////////////

  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // One memory word seen as a flat vector by the buffer
  // and as four lanes by the array
  // Lane i is row i for A, column j for B
  typedef union packed {
    logic [`MM_TILE*`MM_DWIDTH-1:0] raw;
    elem_t [`MM_TILE-1:0]           lanes;
  } operand_word_u;

  //////////////////////////////////////////////////
  // Result row
  //////////////////////////////////////////////////

  // Element j of the row sits in lane j
  typedef elem_t [`MM_TILE-1:0] c_row_t;

endpackage

`default_nettype wire

/* common/matmul_ctrl_pkg.sv */
`default_nettype none

`include "matmul_defs.svh"

package matmul_ctrl_pkg;

  // Target bank of a host write
  typedef enum logic {
    MAT_A = 1'b0,
    MAT_B = 1'b1
  } mat_sel_e;

  //////////////////////////////////////////////////
  // Host write word, 36 bits
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                           valid;
    mat_sel_e                       sel;
    logic [`MM_AWIDTH-1:0]          addr;
    matmul_data_pkg::operand_word_u data;
  } host_wr_t;

  //////////////////////////////////////////////////
  // Result beat, 35 bits
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                        valid;
    logic [$clog2(`MM_TILE)-1:0] row_idx;
    matmul_data_pkg::c_row_t     row;
  } result_beat_t;

endpackage

`default_nettype wire

/* systolic_array/processing_element.sv */
`timescale 1ns/1ps
`default_nettype none

module processing_element (
  input  wire                         clk_mem,
  input  wire                         reset,
  input  wire                         acc_clear,
  input  wire matmul_data_pkg::elem_t in_a,
  input  wire matmul_data_pkg::elem_t in_b,
  output matmul_data_pkg::elem_t      out_a,
  output matmul_data_pkg::elem_t      out_b,
  output matmul_data_pkg::elem_t      acc
);

  localparam int DW = $bits(matmul_data_pkg::elem_t);

  logic [2*DW-1:0] prod;

  // Full product, only the low byte is kept
  assign prod = in_a * in_b;

  // Operands move one cell right and one cell down per cycle
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // Accumulate modulo 256
  always_ff @(posedge clk_mem) begin
    if (reset || acc_clear) begin
      acc <= '0;
    end else begin
      acc <= acc + prod[DW-1:0];
    end
  end

endmodule

`default_nettype wire

/* systolic_array/systolic_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_defs.svh"

module systolic_array (
  input  wire                                 clk_mem,
  input  wire                                 reset,
  input  wire matmul_data_pkg::operand_word_u a_word,
  input  wire matmul_data_pkg::operand_word_u b_word,
  input  wire                                 feed_valid,
  input  wire                                 acc_clear,
  output wire matmul_data_pkg::c_row_t        c_matrix [`MM_TILE]
);

  localparam int DW = $bits(matmul_data_pkg::elem_t);

  // A travels right along a row, B travels down a column
  // Index TILE is the spill out of the far edge
  wire matmul_data_pkg::elem_t a_h [`MM_TILE][`MM_TILE+1];
  wire matmul_data_pkg::elem_t b_v [`MM_TILE+1][`MM_TILE];

  genvar i, j;

  //////////////////////////////////////////////////
  // Input skew, lane i delayed by i cycles
  //////////////////////////////////////////////////

  for (i = 0; i < `MM_TILE; i++) begin : g_skew
    matmul_data_pkg::elem_t a_gate;
    matmul_data_pkg::elem_t b_gate;

    assign a_gate = feed_valid ? a_word.lanes[i] : '0;
    assign b_gate = feed_valid ? b_word.lanes[i] : '0;

    if (i == 0) begin : g_direct
      assign a_h[i][0] = a_gate;
      assign b_v[0][i] = b_gate;
    end else begin : g_dly
      // Newest element in slot 0, oldest in slot i-1
      matmul_data_pkg::elem_t [i-1:0] a_sr;
      matmul_data_pkg::elem_t [i-1:0] b_sr;

      always_ff @(posedge clk_mem) begin
        if (reset) begin
          a_sr <= '0;
          b_sr <= '0;
        end else begin
          a_sr <= (a_sr << DW) | a_gate;
          b_sr <= (b_sr << DW) | b_gate;
        end
      end

      assign a_h[i][0] = a_sr[i-1];
      assign b_v[0][i] = b_sr[i-1];
    end
  end

  //////////////////////////////////////////////////
  // PE grid
  //////////////////////////////////////////////////

  for (i = 0; i < `MM_TILE; i++) begin : g_row
    for (j = 0; j < `MM_TILE; j++) begin : g_col
      processing_element u_pe (
        .clk_mem   (clk_mem),
        .reset     (reset),
        .acc_clear (acc_clear),
        .in_a      (a_h[i][j]),
        .in_b      (b_v[i][j]),
        .out_a     (a_h[i][j+1]),
        .out_b     (b_v[i+1][j]),
        .acc       (c_matrix[i][j])
      );
    end
  end

endmodule

`default_nettype wire

/* logic/operand_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_defs.svh"

module operand_buffer (
  input  wire                            clk_mem,
  input  wire                            reset,
  input  wire matmul_ctrl_pkg::host_wr_t host_wr,
  input  wire                            busy,
  input  wire                            rd_en,
  input  wire [`MM_AWIDTH-1:0]           rd_addr,
  output matmul_data_pkg::operand_word_u a_word,
  output matmul_data_pkg::operand_word_u b_word
);

  // Column k of A and row k of B at address k
  logic [`MM_TILE*`MM_DWIDTH-1:0] bank_a [`MM_DEPTH];
  logic [`MM_TILE*`MM_DWIDTH-1:0] bank_b [`MM_DEPTH];

  logic wr_ok;

  // Host writes only land while the tile is idle
  assign wr_ok = host_wr.valid && !busy;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (wr_ok) begin
      if (host_wr.sel == matmul_ctrl_pkg::MAT_A) begin
        bank_a[host_wr.addr] <= host_wr.data.raw;
      end else begin
        bank_b[host_wr.addr] <= host_wr.data.raw;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Zero outside a read so the array sees no stale operands
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      a_word.raw <= '0;
      b_word.raw <= '0;
    end else if (rd_en) begin
      a_word.raw <= bank_a[rd_addr];
      b_word.raw <= bank_b[rd_addr];
    end else begin
      a_word.raw <= '0;
      b_word.raw <= '0;
    end
  end

endmodule

`default_nettype wire

/* logic/matmul_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_defs.svh"

module matmul_sequencer (
  input  wire                   clk_mem,
  input  wire                   reset,
  input  wire                   start,
  input  wire                   draining,
  output logic                  busy,
  output logic                  rd_en,
  output logic [`MM_AWIDTH-1:0] rd_addr,
  output logic                  acc_clear,
  output logic                  feed_valid,
  output logic                  capture,
  output logic                  done
);

  localparam int CNT_W = $clog2(`MM_COMPUTE_CYCLES + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`MM_COMPUTE_CYCLES);
  localparam logic [CNT_W-1:0] LAST_RD = CNT_W'(`MM_DEPTH);
  localparam logic [CNT_W-1:0] LAST_FEED = CNT_W'(`MM_DEPTH + 1);

  // Cycles since the accepted start, 1 in the first busy cycle
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_m1;
  logic             at_last;

  //////////////////////////////////////////////////
  // Cycle counter
  //////////////////////////////////////////////////

  // A start while busy is dropped
  // At the last count the result waits until the streamer has
  // sent every row of the previous set
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (!busy) begin
      if (start) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(1);
      end
    end else if (cnt == LAST) begin
      if (!draining) begin
        busy <= 1'b0;
        cnt  <= '0;
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Decoded controls
  //////////////////////////////////////////////////

  assign cnt_m1  = cnt - 1'b1;
  assign rd_addr = cnt_m1[`MM_AWIDTH-1:0];

  // Reads on counts 1..DEPTH, data valid one count later
  assign rd_en      = busy && (cnt <= LAST_RD);
  assign feed_valid = busy && (cnt >= CNT_W'(2)) && (cnt <= LAST_FEED);
  assign acc_clear  = busy && (cnt == CNT_W'(1));

  assign at_last = busy && (cnt == LAST);
  assign capture = at_last && !draining;
  assign done    = capture;

endmodule

`default_nettype wire

/* logic/result_streamer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_defs.svh"

module result_streamer (
  input  wire                          clk_mem,
  input  wire                          reset,
  input  wire                          capture,
  input  wire matmul_data_pkg::c_row_t c_matrix [`MM_TILE],
  input  wire                          result_credit,
  output logic                         draining,
  output matmul_ctrl_pkg::result_beat_t result
);

  localparam int ROW_W = $clog2(`MM_TILE);
  // Headroom for credits the host returns early
  localparam int CREDIT_W = $clog2(`MM_CREDITS + 1) + 2;

  matmul_data_pkg::c_row_t rows_q [`MM_TILE];

  logic [ROW_W-1:0]    row_ptr;
  logic [CREDIT_W-1:0] credits;
  logic                send;

  assign send = draining && (credits != '0);

  //////////////////////////////////////////////////
  // Row capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (capture) begin
      rows_q <= c_matrix;
    end
  end

  //////////////////////////////////////////////////
  // Row pointer and credits
  //////////////////////////////////////////////////

  // Capture only comes while not draining, so it never meets a send
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      draining <= 1'b0;
      row_ptr  <= '0;
    end else if (capture) begin
      draining <= 1'b1;
      row_ptr  <= '0;
    end else if (send) begin
      row_ptr <= row_ptr + 1'b1;
      if (row_ptr == ROW_W'(`MM_TILE - 1)) begin
        draining <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      credits <= CREDIT_W'(`MM_CREDITS);
    end else begin
      case ({send, result_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // One row per cycle while credits last
  assign result = '{valid: send, row_idx: row_ptr, row: rows_q[row_ptr]};

endmodule

`default_nettype wire

/* logic/matmul_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_defs.svh"

module matmul_top (
  input  wire                            clk_mem,
  input  wire                            reset,
  input  wire matmul_ctrl_pkg::host_wr_t host_wr,
  input  wire                            start,
  input  wire                            result_credit,
  output wire                            done,
  output matmul_ctrl_pkg::result_beat_t  result
);

  wire                                 busy;
  wire                                 rd_en;
  wire [`MM_AWIDTH-1:0]                rd_addr;
  wire                                 acc_clear;
  wire                                 feed_valid;
  wire                                 capture;
  wire                                 draining;
  wire matmul_data_pkg::operand_word_u a_word;
  wire matmul_data_pkg::operand_word_u b_word;
  wire matmul_data_pkg::c_row_t        c_matrix [`MM_TILE];

  operand_buffer u_operand_buffer (
    .clk_mem (clk_mem),
    .reset   (reset),
    .host_wr (host_wr),
    .busy    (busy),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .a_word  (a_word),
    .b_word  (b_word)
  );

  matmul_sequencer u_matmul_sequencer (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .start      (start),
    .draining   (draining),
    .busy       (busy),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .acc_clear  (acc_clear),
    .feed_valid (feed_valid),
    .capture    (capture),
    .done       (done)
  );

  systolic_array u_systolic_array (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .a_word     (a_word),
    .b_word     (b_word),
    .feed_valid (feed_valid),
    .acc_clear  (acc_clear),
    .c_matrix   (c_matrix)
  );

  result_streamer u_result_streamer (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .capture       (capture),
    .c_matrix      (c_matrix),
    .result_credit (result_credit),
    .draining      (draining),
    .result        (result)
  );

endmodule

`default_nettype wire

/* testbench/matmul_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_defs.svh"

module matmul_checker (
  input  wire                                clk_mem,
  input  wire                                reset,
  input  wire matmul_ctrl_pkg::host_wr_t     host_wr,
  input  wire                                start,
  input  wire                                result_credit,
  input  wire                                done,
  input  wire matmul_ctrl_pkg::result_beat_t result,
  input  wire                                test_end,
  input  wire [7:0]                          test_num,
  input  wire [127:0]                        test_name,
  input  wire                                tb_error,
  input  wire                                report,
  output int                                 error_total
);

  localparam int T = `MM_TILE;
  localparam int ROW_W = $clog2(`MM_TILE);

  // Host view of A (column k per word) and B (row k per word)
  matmul_data_pkg::elem_t  model_a [T][`MM_DEPTH];
  matmul_data_pkg::elem_t  model_b [`MM_DEPTH][T];
  matmul_data_pkg::c_row_t exp_rows [$];

  logic busy_model;
  int   credits;
  int   exp_idx;
  int   test_errors;
  int   tests_run;
  int   tests_failed;

  initial begin
    error_total  = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Row i of C, each element the dot product modulo 256
  function automatic matmul_data_pkg::c_row_t expected_row(input int i);
    int sum;
    matmul_data_pkg::c_row_t row;
    for (int j = 0; j < T; j++) begin
      sum = 0;
      for (int k = 0; k < `MM_DEPTH; k++) begin
        sum += model_a[i][k] * model_b[k][j];
      end
      row[j] = 8'(sum % 256);
    end
    return row;
  endfunction

  task automatic store_word(input matmul_ctrl_pkg::host_wr_t w);
    for (int l = 0; l < T; l++) begin
      if (w.sel == matmul_ctrl_pkg::MAT_A) begin
        model_a[l][w.addr] = w.data.lanes[l];
      end else begin
        model_b[w.addr][l] = w.data.lanes[l];
      end
    end
  endtask

  task automatic fail_words(input string msg);
    $display("Failure at %0t ns: %0s", $time, msg);
    test_errors++;
  endtask

  //////////////////////////////////////////////////
  // Beat and credit checks
  //////////////////////////////////////////////////

  task automatic check_beat;
    matmul_data_pkg::c_row_t want;
    logic [ROW_W-1:0]        want_idx;
    if (credits <= 0) begin
      fail_words("result beat sent while the host held no credit");
    end else begin
      credits--;
    end
    if (exp_rows.size() == 0) begin
      fail_words("result beat with no result set pending");
    end else begin
      want     = exp_rows.pop_front();
      want_idx = exp_idx[ROW_W-1:0];
      if (result.row_idx !== want_idx) begin
        $display("ERR result.row_idx expected %h actual %h", want_idx, result.row_idx);
        test_errors++;
      end
      if (result.row !== want) begin
        $display("ERR result.row expected %h actual %h", want, result.row);
        test_errors++;
      end
      exp_idx = (exp_idx + 1) % T;
    end
  endtask

  task automatic close_test;
    if (busy_model) begin
      fail_words("a computation is still running at the end of the test");
    end
    if (exp_rows.size() != 0) begin
      fail_words("result rows are still pending at the end of the test");
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %0s: ok", test_num, test_name);
    end else begin
      $display("test %0d %0s: FAILED with %0d errors", test_num, test_name, test_errors);
      tests_failed++;
    end
    error_total += test_errors;
    test_errors = 0;
  endtask

  always @(posedge clk_mem) begin : watch
    logic start_ok;
    if (reset) begin
      busy_model = 1'b0;
      credits    = `MM_CREDITS;
      exp_idx    = 0;
      exp_rows.delete();
    end else begin
      // A start only counts while no computation runs
      start_ok = start && !busy_model;
      if (host_wr.valid && !busy_model) begin
        store_word(host_wr);
      end
      if (done) begin
        if (!busy_model) begin
          fail_words("done pulsed with no computation running");
        end
        busy_model = 1'b0;
      end
      if (start_ok) begin
        busy_model = 1'b1;
        for (int i = 0; i < T; i++) begin
          exp_rows.push_back(expected_row(i));
        end
      end
      // Credit seen before the returned one, as in the streamer
      if (result.valid) begin
        check_beat();
      end
      if (result_credit) begin
        credits++;
      end
      if (tb_error) begin
        test_errors++;
      end
      if (test_end) begin
        close_test();
      end
      if (report) begin
        error_total += test_errors;
        test_errors = 0;
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_total);
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_matmul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "matmul_defs.svh"

module tb_matmul;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS = 8;
  localparam int T = `MM_TILE;
  // Quiet cycles before a held credit goes back
  localparam int HOLD_GAP = 8;
  localparam int DONE_LIMIT = `MM_COMPUTE_CYCLES + 8;
  localparam int BEAT_LIMIT = 40;
  // Watchdog budget, an overlap test runs two sets
  localparam int LOAD_CYCLES = 2 * `MM_DEPTH + 2;
  localparam int CREDIT_DELAY = T * (HOLD_GAP + 2);
  localparam int MARGIN = 60;
  localparam int TEST_CYCLES = 2 * (LOAD_CYCLES + `MM_COMPUTE_CYCLES) + CREDIT_DELAY + MARGIN;

  typedef enum logic [2:0] {K_IDENT, K_ZERO, K_ONES, K_RANDOM, K_REPEAT, K_OVERLAP} kind_e;
  typedef enum logic [1:0] {CR_EAGER, CR_HOLD, CR_NONE} credit_e;

  typedef struct packed {
    kind_e        kind;
    credit_e      credit;
    logic [127:0] name;
  } test_entry_t;

  logic                          clk_mem;
  logic                          reset;
  matmul_ctrl_pkg::host_wr_t     host_wr;
  logic                          start;
  logic                          result_credit;
  logic                          done;
  matmul_ctrl_pkg::result_beat_t result;

  logic         test_end;
  logic [7:0]   test_num;
  logic [127:0] test_name;
  logic         tb_error;
  logic         report;
  int           error_total;

  test_entry_t            tests [NUM_TESTS];
  matmul_data_pkg::elem_t a_m [T][`MM_DEPTH];
  matmul_data_pkg::elem_t b_m [`MM_DEPTH][T];
  logic [31:0]            lfsr_state;
  // Beats received but not yet credited back
  int                     owed;

  matmul_top uut (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .host_wr       (host_wr),
    .start         (start),
    .result_credit (result_credit),
    .done          (done),
    .result        (result)
  );

  matmul_checker u_checker (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .host_wr       (host_wr),
    .start         (start),
    .result_credit (result_credit),
    .done          (done),
    .result        (result),
    .test_end      (test_end),
    .test_num      (test_num),
    .test_name     (test_name),
    .tb_error      (tb_error),
    .report        (report),
    .error_total   (error_total)
  );

  initial begin
    clk_mem = 1'b0;
    forever #(CLK_PERIOD / 2) clk_mem = ~clk_mem;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_elem(output matmul_data_pkg::elem_t e);
    for (int b = 0; b < `MM_DWIDTH; b++) begin
      e[b]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic add_test(input int idx, input kind_e kind, input credit_e credit,
                          input logic [127:0] name);
    tests[idx].kind   = kind;
    tests[idx].credit = credit;
    tests[idx].name   = name;
  endtask

  task automatic fill_matrices(input kind_e kind);
    for (int r = 0; r < T; r++) begin
      for (int c = 0; c < T; c++) begin
        case (kind)
          K_IDENT: begin
            a_m[r][c] = (r == c) ? 8'd1 : 8'd0;
            b_m[r][c] = 8'(r * T + c + 1);
          end
          K_ZERO: begin
            a_m[r][c] = 8'h00;
            b_m[r][c] = 8'h00;
          end
          K_ONES: begin
            a_m[r][c] = 8'hff;
            b_m[r][c] = 8'hff;
          end
          default: begin
            random_elem(a_m[r][c]);
            random_elem(b_m[r][c]);
          end
        endcase
      end
    end
  endtask

  // Word k carries column k of A and row k of B
  task automatic load_matrices;
    matmul_data_pkg::operand_word_u wa;
    matmul_data_pkg::operand_word_u wb;
    for (int k = 0; k < `MM_DEPTH; k++) begin
      for (int l = 0; l < T; l++) begin
        wa.lanes[l] = a_m[l][k];
        wb.lanes[l] = b_m[k][l];
      end
      @(negedge clk_mem);
      host_wr = '{valid: 1'b1, sel: matmul_ctrl_pkg::MAT_A, addr: k[`MM_AWIDTH-1:0], data: wa};
      @(negedge clk_mem);
      host_wr = '{valid: 1'b1, sel: matmul_ctrl_pkg::MAT_B, addr: k[`MM_AWIDTH-1:0], data: wb};
    end
    @(negedge clk_mem);
    host_wr = '0;
  endtask

  task automatic pulse_start;
    @(negedge clk_mem);
    start = 1'b1;
    @(negedge clk_mem);
    start = 1'b0;
  endtask

  task automatic flag_tb_error;
    tb_error = 1'b1;
    @(negedge clk_mem);
    tb_error = 1'b0;
  endtask

  task automatic wait_done;
    int n;
    n = 0;
    while (!done && n < DONE_LIMIT) begin
      @(negedge clk_mem);
      n++;
    end
    if (!done) begin
      $display("done did not arrive within %0d cycles of start", DONE_LIMIT);
      flag_tb_error();
    end
  endtask

  //////////////////////////////////////////////////
  // Result collection and credit return
  //////////////////////////////////////////////////

  task automatic collect_beats(input int n, input credit_e mode);
    int seen;
    int quiet;
    seen  = 0;
    quiet = 0;
    while (seen < n && quiet < BEAT_LIMIT) begin
      @(negedge clk_mem);
      result_credit = 1'b0;
      if (result.valid) begin
        seen++;
        owed++;
        quiet = 0;
      end else begin
        quiet++;
      end
      if (mode == CR_EAGER && owed > 0) begin
        result_credit = 1'b1;
        owed--;
      end else if (mode == CR_HOLD && seen >= `MM_CREDITS && owed > 0 && quiet >= HOLD_GAP) begin
        // One credit at a time, each should free exactly one row
        result_credit = 1'b1;
        owed--;
        quiet = 0;
      end
    end
    if (seen < n) begin
      $display("Only %0d of %0d result beats arrived, none for %0d cycles", seen, n, BEAT_LIMIT);
      flag_tb_error();
    end
  endtask

  task automatic return_credits;
    while (owed > 0) begin
      @(negedge clk_mem);
      result_credit = 1'b1;
      owed--;
    end
    @(negedge clk_mem);
    result_credit = 1'b0;
  endtask

  task automatic run_test(input test_entry_t t);
    if (t.kind != K_REPEAT) begin
      fill_matrices(t.kind);
      load_matrices();
    end
    pulse_start();
    wait_done();
    if (t.kind == K_OVERLAP) begin
      // Second set starts while rows of the first are held back
      collect_beats(`MM_CREDITS, CR_NONE);
      fill_matrices(K_RANDOM);
      load_matrices();
      pulse_start();
      // Its compute ends while the first set still waits for credits
      repeat (`MM_COMPUTE_CYCLES + 4) @(negedge clk_mem);
      collect_beats(2 * T - `MM_CREDITS, t.credit);
    end else begin
      collect_beats(T, t.credit);
    end
    return_credits();
    repeat (4) @(negedge clk_mem);
  endtask

  initial begin
    reset         = 1'b1;
    host_wr       = '0;
    start         = 1'b0;
    result_credit = 1'b0;
    test_end      = 1'b0;
    test_num      = '0;
    test_name     = '0;
    tb_error      = 1'b0;
    report        = 1'b0;
    owed          = 0;
    lfsr_state    = 32'h6a37_2615;
    add_test(0, K_IDENT,   CR_EAGER, "identity");
    add_test(1, K_ZERO,    CR_EAGER, "zeros");
    add_test(2, K_ONES,    CR_HOLD,  "all_ff_hold");
    add_test(3, K_RANDOM,  CR_EAGER, "random_a");
    add_test(4, K_RANDOM,  CR_HOLD,  "random_hold");
    add_test(5, K_REPEAT,  CR_EAGER, "repeat_start");
    add_test(6, K_OVERLAP, CR_EAGER, "overlap");
    add_test(7, K_RANDOM,  CR_EAGER, "random_b");
    repeat (RESET_CYCLES) @(negedge clk_mem);
    reset = 1'b0;
    // Idle window, the checker flags any done or beat here
    repeat (8) @(negedge clk_mem);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(tests[t]);
      test_num  = 8'(t);
      test_name = tests[t].name;
      test_end  = 1'b1;
      @(negedge clk_mem);
      test_end  = 1'b0;
    end
    report = 1'b1;
    @(negedge clk_mem);
    report = 1'b0;
    @(negedge clk_mem);
    if (error_total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (RESET_CYCLES + 20 + NUM_TESTS * TEST_CYCLES) @(posedge clk_mem);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/matmul_data_pkg.sv
common/matmul_ctrl_pkg.sv
systolic_array/processing_element.sv
systolic_array/systolic_array.sv
logic/operand_buffer.sv
logic/matmul_sequencer.sv
logic/result_streamer.sv
logic/matmul_top.sv
testbench/matmul_checker.sv
testbench/tb_matmul.sv

/* Bender.yml */
package:
  name: matmul_tile

sources:
  - include_dirs:
      - common
    files:
      - common/matmul_data_pkg.sv
      - common/matmul_ctrl_pkg.sv
      - systolic_array/processing_element.sv
      - systolic_array/systolic_array.sv
      - logic/operand_buffer.sv
      - logic/matmul_sequencer.sv
      - logic/result_streamer.sv
      - logic/matmul_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - testbench/matmul_checker.sv
      - testbench/tb_matmul.sv
